//--- logic/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // ========================================================================
    // Sizes
    // ========================================================================

    localparam int XLEN     = 32;
    localparam int NUM_FU   = 3;
    localparam int TAG_W    = 5;
    // Index width for selecting one functional unit
    localparam int FU_IDX_W = $clog2(NUM_FU);

    // Sequential instruction step, used for link values and fall-through
    localparam logic [XLEN-1:0] PC_STEP = 4;

    typedef logic [FU_IDX_W-1:0] fu_idx_t;

    // ========================================================================
    // Operation encodings
    // ========================================================================

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } alu_op_e;

    // Conditional branches sit between NONE and the two jumps
    typedef enum logic [3:0] {
        NONE = 4'd0,
        BEQ  = 4'd1,
        BNE  = 4'd2,
        BLT  = 4'd3,
        BGE  = 4'd4,
        BLTU = 4'd5,
        BGEU = 4'd6,
        JAL  = 4'd7,
        JALR = 4'd8
    } branch_op_e;

    // ========================================================================
    // Packets
    // ========================================================================

    // Router to functional unit
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        alu_op_e          alu_op;
        branch_op_e       branch_op;
        logic [XLEN-1:0]  data_a;
        logic [XLEN-1:0]  data_b;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  target_pc;
        logic             predict_taken;
    } issue_pkt_t;

    // Common data bus broadcast
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  data;
        logic             is_branch;
        logic             mispredict;
        logic [XLEN-1:0]  correct_pc;
    } cdb_pkt_t;

    typedef struct packed {
        logic zero;
        logic negative;
        logic carry;
        logic overflow;
    } alu_flags_t;

endpackage

`default_nettype wire

//--- logic/alu_shifter.sv
`timescale 1ns/10ps
`default_nettype none

module alu_shifter (
    input  exec_pkg::alu_op_e              alu_op,
    input  logic [exec_pkg::XLEN-1:0]      data_a,
    input  logic [exec_pkg::XLEN-1:0]      data_b,
    output logic [exec_pkg::XLEN-1:0]      result,
    output exec_pkg::alu_flags_t           flags
);

    // Shared adder, subtracts for SUB and both compares
    logic                        sub;
    logic [exec_pkg::XLEN-1:0]   b_eff;
    logic [exec_pkg::XLEN:0]     sum;
    logic                        add_ovf;
    logic                        addsub;
    logic [4:0]                  shamt;

    assign sub    = (alu_op == exec_pkg::SUB) || (alu_op == exec_pkg::SLT) ||
                    (alu_op == exec_pkg::SLTU);
    assign addsub = (alu_op == exec_pkg::ADD) || (alu_op == exec_pkg::SUB);
    assign b_eff  = sub ? ~data_b : data_b;
    assign sum    = {1'b0, data_a} + {1'b0, b_eff} + {{exec_pkg::XLEN{1'b0}}, sub};
    // Signed overflow when operand signs agree and the sum sign flips
    assign add_ovf = (data_a[exec_pkg::XLEN-1] == b_eff[exec_pkg::XLEN-1]) &&
                     (sum[exec_pkg::XLEN-1] != data_a[exec_pkg::XLEN-1]);
    assign shamt  = data_b[4:0];

    always_comb begin
        case (alu_op)
            exec_pkg::ADD,
            exec_pkg::SUB:  result = sum[exec_pkg::XLEN-1:0];
            exec_pkg::SLL:  result = data_a << shamt;
            // Signed less-than is sign of difference corrected by overflow
            exec_pkg::SLT:  result = {{(exec_pkg::XLEN-1){1'b0}},
                                      sum[exec_pkg::XLEN-1] ^ add_ovf};
            // Unsigned borrow shows as missing carry out
            exec_pkg::SLTU: result = {{(exec_pkg::XLEN-1){1'b0}}, ~sum[exec_pkg::XLEN]};
            exec_pkg::XOR:  result = data_a ^ data_b;
            exec_pkg::SRL:  result = data_a >> shamt;
            exec_pkg::SRA:  result = $signed(data_a) >>> shamt;
            exec_pkg::OR:   result = data_a | data_b;
            exec_pkg::AND:  result = data_a & data_b;
            default:        result = sum[exec_pkg::XLEN-1:0];
        endcase
    end

    // Zero and negative follow the result
    assign flags.zero     = (result == '0);
    assign flags.negative = result[exec_pkg::XLEN-1];
    // Carry and overflow only meaningful on the add/sub path
    assign flags.carry    = addsub & sum[exec_pkg::XLEN];
    assign flags.overflow = addsub & add_ovf;

endmodule

`default_nettype wire

//--- logic/branch_resolver.sv
`timescale 1ns/10ps
`default_nettype none

module branch_resolver (
    input  exec_pkg::branch_op_e branch_op,
    input  exec_pkg::alu_flags_t flags,
    output logic                 taken,
    output logic                 reg_jump
);

    // Signed compare from the SUB flags
    logic lt_signed;

    assign lt_signed = flags.negative ^ flags.overflow;

    always_comb begin
        taken    = 1'b0;
        reg_jump = 1'b0;
        case (branch_op)
            exec_pkg::BEQ:  taken = flags.zero;
            exec_pkg::BNE:  taken = ~flags.zero;
            exec_pkg::BLT:  taken = lt_signed;
            exec_pkg::BGE:  taken = ~lt_signed;
            // Carry out of a - b means no borrow, so a >= b unsigned
            exec_pkg::BLTU: taken = ~flags.carry;
            exec_pkg::BGEU: taken = flags.carry;
            // Jumps always redirect
            exec_pkg::JAL:  taken = 1'b1;
            exec_pkg::JALR: begin
                taken    = 1'b1;
                reg_jump = 1'b1;
            end
            default: begin
                taken    = 1'b0;
                reg_jump = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/exec_unit.sv
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  exec_pkg::issue_pkt_t in_pkt,
    output logic                 ready,
    input  logic                 grant,
    output logic                 res_valid,
    output exec_pkg::cdb_pkt_t   res_pkt
);

    exec_pkg::alu_op_e         alu_op;
    logic [exec_pkg::XLEN-1:0] alu_result;
    exec_pkg::alu_flags_t      flags;
    logic                      taken;
    logic                      reg_jump;
    logic                      is_cond;
    logic                      is_jump;
    logic [exec_pkg::XLEN-1:0] link_pc;
    exec_pkg::cdb_pkt_t        next_pkt;
    logic                      accept;

    // ========================================================================
    // Operation decode
    // ========================================================================

    always_comb begin
        is_cond = 1'b0;
        is_jump = 1'b0;
        alu_op  = in_pkt.alu_op;
        case (in_pkt.branch_op)
            exec_pkg::BEQ, exec_pkg::BNE, exec_pkg::BLT,
            exec_pkg::BGE, exec_pkg::BLTU, exec_pkg::BGEU: begin
                // Compare by subtraction
                is_cond = 1'b1;
                alu_op  = exec_pkg::SUB;
            end
            exec_pkg::JAL:  is_jump = 1'b1;
            exec_pkg::JALR: begin
                // Target is rs1 plus offset
                is_jump = 1'b1;
                alu_op  = exec_pkg::ADD;
            end
            default: ;
        endcase
    end

    alu_shifter u_alu (
        .alu_op (alu_op),
        .data_a (in_pkt.data_a),
        .data_b (in_pkt.data_b),
        .result (alu_result),
        .flags  (flags)
    );

    branch_resolver u_br (
        .branch_op (in_pkt.branch_op),
        .flags     (flags),
        .taken     (taken),
        .reg_jump  (reg_jump)
    );

    // ========================================================================
    // Result packet
    // ========================================================================

    assign link_pc = in_pkt.pc + exec_pkg::PC_STEP;

    always_comb begin
        next_pkt.tag        = in_pkt.tag;
        next_pkt.is_branch  = is_cond;
        next_pkt.mispredict = (is_cond | is_jump) & (taken ^ in_pkt.predict_taken);
        if (is_cond) begin
            next_pkt.data       = '0;
            next_pkt.correct_pc = taken ? in_pkt.target_pc : link_pc;
        end else if (is_jump) begin
            // JALR target is word aligned from the adder
            next_pkt.data       = link_pc;
            next_pkt.correct_pc = reg_jump ? {alu_result[exec_pkg::XLEN-1:2], 2'b00}
                                           : in_pkt.target_pc;
        end else begin
            next_pkt.data       = alu_result;
            next_pkt.correct_pc = '0;
        end
    end

    // Free when empty or draining this cycle
    assign ready  = ~res_valid | grant;
    assign accept = in_valid & ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (accept) begin
            res_valid <= 1'b1;
        end else if (grant) begin
            res_valid <= 1'b0;
        end
    end

    // Payload holds until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            res_pkt <= next_pkt;
        end
    end

endmodule

`default_nettype wire

//--- logic/issue_router.sv
`timescale 1ns/10ps
`default_nettype none

module issue_router (
    input  logic                         dispatch_valid,
    input  exec_pkg::issue_pkt_t         dispatch_pkt,
    output logic                         dispatch_ready,
    input  logic [exec_pkg::NUM_FU-1:0]  fu_ready,
    output logic [exec_pkg::NUM_FU-1:0]  fu_valid,
    output exec_pkg::issue_pkt_t         fu_pkt
);

    // One-hot pick of the lowest ready unit
    logic [exec_pkg::NUM_FU-1:0] sel;

    always_comb begin
        logic found;
        found = 1'b0;
        sel   = '0;
        for (int i = 0; i < exec_pkg::NUM_FU; i++) begin
            if (fu_ready[i] && !found) begin
                sel[i] = 1'b1;
                found  = 1'b1;
            end
        end
    end

    // Any free unit can take the instruction
    assign dispatch_ready = |fu_ready;

    // Only the selected unit sees a valid
    assign fu_valid = dispatch_valid ? sel : '0;

    // Same packet fans out to every unit
    assign fu_pkt = dispatch_pkt;

endmodule

`default_nettype wire

//--- logic/cdb_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module cdb_arbiter (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cdb_hold,
    input  logic [exec_pkg::NUM_FU-1:0]  res_valid,
    input  exec_pkg::cdb_pkt_t           res_pkt [exec_pkg::NUM_FU],
    output logic [exec_pkg::NUM_FU-1:0]  grant,
    output logic                         cdb_valid,
    output exec_pkg::cdb_pkt_t           cdb_pkt
);

    // Round-robin start point
    exec_pkg::fu_idx_t ptr;
    exec_pkg::fu_idx_t win_idx;
    exec_pkg::fu_idx_t next_ptr;
    logic              any_valid;

    // Search from the pointer, wrapping past the last unit
    always_comb begin
        int idx;
        any_valid = 1'b0;
        win_idx   = '0;
        for (int k = 0; k < exec_pkg::NUM_FU; k++) begin
            idx = int'(ptr) + k;
            if (idx >= exec_pkg::NUM_FU) begin
                idx = idx - exec_pkg::NUM_FU;
            end
            if (res_valid[idx] && !any_valid) begin
                any_valid = 1'b1;
                win_idx   = exec_pkg::fu_idx_t'(idx);
            end
        end
    end

    // Hold from the other producer blocks all grants
    assign cdb_valid = any_valid & ~cdb_hold;
    assign grant     = cdb_valid ? (exec_pkg::NUM_FU'(1) << win_idx) : '0;
    assign cdb_pkt   = cdb_valid ? res_pkt[win_idx] : '0;

    // Next search starts one past the winner
    assign next_ptr = (int'(win_idx) == exec_pkg::NUM_FU - 1) ? '0 : win_idx + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (cdb_valid) begin
            ptr <= next_ptr;
        end
    end

endmodule

`default_nettype wire

//--- logic/exec_cluster.sv
`timescale 1ns/10ps
`default_nettype none

module exec_cluster (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 dispatch_valid,
    input  exec_pkg::issue_pkt_t dispatch_pkt,
    output logic                 dispatch_ready,
    input  logic                 cdb_hold,
    output logic                 cdb_valid,
    output exec_pkg::cdb_pkt_t   cdb_pkt
);

    // Router to units
    logic [exec_pkg::NUM_FU-1:0] fu_valid;
    logic [exec_pkg::NUM_FU-1:0] fu_ready;
    exec_pkg::issue_pkt_t        fu_pkt;

    // Units to bus arbiter
    logic [exec_pkg::NUM_FU-1:0] grant;
    logic [exec_pkg::NUM_FU-1:0] res_valid;
    exec_pkg::cdb_pkt_t          res_pkt [exec_pkg::NUM_FU];

    issue_router u_router (
        .dispatch_valid (dispatch_valid),
        .dispatch_pkt   (dispatch_pkt),
        .dispatch_ready (dispatch_ready),
        .fu_ready       (fu_ready),
        .fu_valid       (fu_valid),
        .fu_pkt         (fu_pkt)
    );

    // ========================================================================
    // Functional units
    // ========================================================================

    for (genvar i = 0; i < exec_pkg::NUM_FU; i++) begin : g_fu
        exec_unit u_fu (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (fu_valid[i]),
            .in_pkt    (fu_pkt),
            .ready     (fu_ready[i]),
            .grant     (grant[i]),
            .res_valid (res_valid[i]),
            .res_pkt   (res_pkt[i])
        );
    end

    cdb_arbiter u_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .cdb_hold  (cdb_hold),
        .res_valid (res_valid),
        .res_pkt   (res_pkt),
        .grant     (grant),
        .cdb_valid (cdb_valid),
        .cdb_pkt   (cdb_pkt)
    );

endmodule

`default_nettype wire

//--- sim/exec_cluster_assert.sv
`timescale 1ns/10ps
`default_nettype none

module exec_cluster_assert (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cdb_hold,
    input  logic                        dispatch_ready,
    input  logic [exec_pkg::NUM_FU-1:0] grant,
    input  logic [exec_pkg::NUM_FU-1:0] res_valid,
    input  exec_pkg::cdb_pkt_t          res_pkt [exec_pkg::NUM_FU]
);

    // At most one unit drives the bus
    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant))
        else $error("CDB grant is not one-hot or zero");

    // Other producer owns the bus while hold is high
    a_no_grant_hold: assert property (@(posedge clk) disable iff (!rst_n)
        cdb_hold |-> (grant == '0))
        else $error("CDB grant raised while cdb_hold was high");

    // Router stalls only with every unit full
    a_ready_full: assert property (@(posedge clk) disable iff (!rst_n)
        !dispatch_ready |-> (&res_valid))
        else $error("dispatch_ready low while a unit was empty");

    // A waiting result keeps its payload
    for (genvar i = 0; i < exec_pkg::NUM_FU; i++) begin : g_hold
        a_result_stable: assert property (@(posedge clk) disable iff (!rst_n)
            (res_valid[i] && !grant[i]) |=> (res_valid[i] && $stable(res_pkt[i])))
            else $error("Held result of unit %0d changed before its grant", i);
    end

endmodule

bind exec_cluster exec_cluster_assert u_assert (
    .clk            (clk),
    .rst_n          (rst_n),
    .cdb_hold       (cdb_hold),
    .dispatch_ready (dispatch_ready),
    .grant          (grant),
    .res_valid      (res_valid),
    .res_pkt        (res_pkt)
);

`default_nettype wire

//--- sim/tb_exec_cluster.sv
`timescale 1ns/10ps
`default_nettype none

module tb_exec_cluster;

    localparam int CLK_PERIOD   = 10;
    localparam int NUM_DISPATCH = 2000;
    localparam int MAX_OUTSTAND = 16;
    localparam int NUM_TAGS     = 1 << exec_pkg::TAG_W;
    // Cycles allowed for the units to empty with hold low
    localparam int DRAIN_LIMIT  = 4 * exec_pkg::NUM_FU;
    // Input drive modes
    localparam int MODE_RANDOM  = 0;
    localparam int MODE_HIGH    = 1;
    localparam int MODE_LOW     = 2;

    logic                 clk;
    logic                 rst_n;
    logic                 dispatch_valid;
    exec_pkg::issue_pkt_t dispatch_pkt;
    logic                 dispatch_ready;
    logic                 cdb_hold;
    logic                 cdb_valid;
    exec_pkg::cdb_pkt_t   cdb_pkt;

    integer                     seed;
    int                         errors;
    int                         n_accepted;
    int                         n_broadcast;
    int                         outstanding;
    int                         drain_cycles;
    bit                         pending;
    logic [exec_pkg::TAG_W-1:0] next_tag;

    // Scoreboard indexed by tag
    exec_pkg::cdb_pkt_t exp_pkt   [NUM_TAGS];
    bit                 exp_valid [NUM_TAGS];
    string              exp_name  [NUM_TAGS];

    exec_cluster UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_pkt   (dispatch_pkt),
        .dispatch_ready (dispatch_ready),
        .cdb_hold       (cdb_hold),
        .cdb_valid      (cdb_valid),
        .cdb_pkt        (cdb_pkt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Run limit scales with the dispatch count
    initial begin
        #(40 * NUM_DISPATCH * CLK_PERIOD);
        $display("Timeout: the run did not finish within the watchdog limit");
        $display("FAIL: see errors above");
        $finish;
    end

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // ========================================================================
    // Reference model
    // ========================================================================

    function automatic exec_pkg::cdb_pkt_t model_result(input exec_pkg::issue_pkt_t p);
        exec_pkg::cdb_pkt_t r;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        link;
        logic [4:0]         sh;
        logic               taken;
        a    = p.data_a;
        b    = p.data_b;
        sh   = b[4:0];
        link = p.pc + 32'd4;
        r    = '0;
        r.tag = p.tag;
        case (p.branch_op)
            exec_pkg::NONE: begin
                case (p.alu_op)
                    exec_pkg::ADD:  r.data = a + b;
                    exec_pkg::SUB:  r.data = a - b;
                    exec_pkg::SLL:  r.data = a << sh;
                    exec_pkg::SLT:  r.data = {31'b0, $signed(a) < $signed(b)};
                    exec_pkg::SLTU: r.data = {31'b0, a < b};
                    exec_pkg::XOR:  r.data = a ^ b;
                    exec_pkg::SRL:  r.data = a >> sh;
                    exec_pkg::SRA:  r.data = $unsigned($signed(a) >>> sh);
                    exec_pkg::OR:   r.data = a | b;
                    default:        r.data = a & b;
                endcase
            end
            // Jumps are always taken and write the link value
            exec_pkg::JAL: begin
                r.data       = link;
                r.correct_pc = p.target_pc;
                r.mispredict = !p.predict_taken;
            end
            exec_pkg::JALR: begin
                r.data       = link;
                r.correct_pc = (a + b) & 32'hffff_fffc;
                r.mispredict = !p.predict_taken;
            end
            default: begin
                case (p.branch_op)
                    exec_pkg::BEQ:  taken = (a == b);
                    exec_pkg::BNE:  taken = (a != b);
                    exec_pkg::BLT:  taken = ($signed(a) < $signed(b));
                    exec_pkg::BGE:  taken = ($signed(a) >= $signed(b));
                    exec_pkg::BLTU: taken = (a < b);
                    default:        taken = (a >= b);
                endcase
                r.is_branch  = 1'b1;
                r.correct_pc = taken ? p.target_pc : link;
                r.mispredict = (taken != p.predict_taken);
            end
        endcase
        return r;
    endfunction

    function automatic string test_name(input exec_pkg::issue_pkt_t p);
        if (p.branch_op == exec_pkg::NONE) begin
            return "alu";
        end else if (p.branch_op == exec_pkg::JAL || p.branch_op == exec_pkg::JALR) begin
            return "jump";
        end
        return "branch";
    endfunction

    // ========================================================================
    // Stimulus
    // ========================================================================

    task automatic make_packet();
        logic [31:0] a;
        logic [31:0] b;
        int          mode;
        int          bsel;
        a    = rand_word();
        b    = rand_word();
        mode = int'(rand_word() % 8);
        // Equal operands and sign boundaries push branches both ways
        case (mode)
            0: b = a;
            1: begin
                a = 32'h8000_0000;
                b = 32'h7fff_ffff;
            end
            2: begin
                a = 32'h7fff_ffff;
                b = 32'h8000_0000;
            end
            3: begin
                a = 32'h0000_0000;
                b = 32'hffff_ffff;
            end
            default: ;
        endcase
        bsel = int'(rand_word() % 12);
        dispatch_pkt.tag           = next_tag;
        dispatch_pkt.alu_op        = exec_pkg::alu_op_e'(4'(rand_word() % 10));
        dispatch_pkt.branch_op     = (bsel < 4) ? exec_pkg::NONE
                                                : exec_pkg::branch_op_e'(4'(bsel - 3));
        dispatch_pkt.data_a        = a;
        dispatch_pkt.data_b        = b;
        dispatch_pkt.pc            = rand_word() & 32'hffff_fffc;
        dispatch_pkt.target_pc     = rand_word() & 32'hffff_fffc;
        dispatch_pkt.predict_taken = 1'(rand_word());
        next_tag = next_tag + 5'd1;
    endtask

    // Packet stays on the port until accepted
    task automatic drive_inputs(input int hold_mode, input int disp_mode);
        bit want;
        case (hold_mode)
            MODE_HIGH: cdb_hold = 1'b1;
            MODE_LOW:  cdb_hold = 1'b0;
            default:   cdb_hold = (rand_word() % 100) < 30;
        endcase
        if (!pending && outstanding < MAX_OUTSTAND && n_accepted < NUM_DISPATCH) begin
            want = (disp_mode == MODE_HIGH) ||
                   (disp_mode == MODE_RANDOM && (rand_word() % 100) < 30);
            if (want) begin
                make_packet();
                pending = 1'b1;
            end
        end
        dispatch_valid = pending;
    endtask

    // ========================================================================
    // Checks
    // ========================================================================

    task automatic check_bus();
        logic [exec_pkg::TAG_W-1:0] t;
        t = cdb_pkt.tag;
        if (cdb_valid) begin
            assert (!cdb_hold) else begin
                errors++;
                $display("Broadcast of tag %0d while cdb_hold was high", t);
            end
            assert (exp_valid[t]) else begin
                errors++;
                $display("Broadcast of tag %0d that is not in flight", t);
            end
            if (exp_valid[t]) begin
                assert (cdb_pkt == exp_pkt[t]) else begin
                    errors++;
                    $display("ERROR %s tag %0d expected %h actual %h",
                             exp_name[t], t, exp_pkt[t], cdb_pkt);
                end
                exp_valid[t] = 1'b0;
                outstanding--;
                n_broadcast++;
            end
        end
    endtask

    task automatic record_accept();
        logic [exec_pkg::TAG_W-1:0] t;
        if (dispatch_valid && dispatch_ready) begin
            t = dispatch_pkt.tag;
            assert (!exp_valid[t]) else begin
                errors++;
                $display("Tag %0d dispatched while still in flight", t);
            end
            exp_pkt[t]   = model_result(dispatch_pkt);
            exp_valid[t] = 1'b1;
            exp_name[t]  = test_name(dispatch_pkt);
            outstanding++;
            n_accepted++;
            pending = 1'b0;
        end
    endtask

    // Drive after the rising edge, sample at the falling edge
    task automatic step(input int hold_mode, input int disp_mode);
        @(posedge clk);
        #1;
        drive_inputs(hold_mode, disp_mode);
        @(negedge clk);
        check_bus();
        record_accept();
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        seed           = 83;
        errors         = 0;
        n_accepted     = 0;
        n_broadcast    = 0;
        outstanding    = 0;
        drain_cycles   = 0;
        pending        = 1'b0;
        next_tag       = '0;
        rst_n          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_pkt   = '0;
        cdb_hold       = 1'b0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            exp_valid[i] = 1'b0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Idle after reset
        @(negedge clk);
        assert (!cdb_valid) else begin
            errors++;
            $display("cdb_valid high right after reset");
        end
        assert (dispatch_ready) else begin
            errors++;
            $display("dispatch_ready low right after reset");
        end

        // Fill all three units under hold
        repeat (6) step(MODE_HIGH, MODE_HIGH);
        assert (n_accepted == 3) else begin
            errors++;
            $display("ERROR backpressure expected %0d actual %0d", 3, n_accepted);
        end
        assert (!dispatch_ready) else begin
            errors++;
            $display("dispatch_ready stayed high with all units full");
        end
        // Releasing hold drains one result and frees a unit
        step(MODE_LOW, MODE_HIGH);
        assert (cdb_valid && dispatch_ready) else begin
            errors++;
            $display("No broadcast or no dispatch_ready after hold was released");
        end

        // Random traffic and hold
        while (n_accepted < NUM_DISPATCH) begin
            step(MODE_RANDOM, MODE_RANDOM);
        end
        // Drain the units within a bounded number of cycles
        while (outstanding > 0 && drain_cycles < DRAIN_LIMIT) begin
            step(MODE_LOW, MODE_LOW);
            drain_cycles++;
        end

        for (int i = 0; i < NUM_TAGS; i++) begin
            assert (!exp_valid[i]) else begin
                errors++;
                $display("Tag %0d was accepted but never broadcast", i);
            end
        end
        assert (n_broadcast == n_accepted) else begin
            errors++;
            $display("ERROR broadcast_count expected %0d actual %0d", n_accepted, n_broadcast);
        end

        $display("Dispatched %0d, broadcast %0d, errors %0d", n_accepted, n_broadcast, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
logic/exec_pkg.sv
logic/alu_shifter.sv
logic/branch_resolver.sv
logic/exec_unit.sv
logic/issue_router.sv
logic/cdb_arbiter.sv
logic/exec_cluster.sv
sim/exec_cluster_assert.sv
sim/tb_exec_cluster.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the exec_cluster testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f flist.f \
    --top-module tb_exec_cluster \
    -Mdir obj_dir

./obj_dir/Vtb_exec_cluster 2>&1 | tee "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi

echo "Simulation passed, log in $LOG"
exit 0
